//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_pov_display
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = NO ERRORS
FAIL_MSG = ERRORS FOUND

SOURCES  = $(wildcard hw/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
hw/pov_pkg.sv
hw/spi_slave.sv
hw/spi_decoder.sv
hw/framebuffer.sv
hw/driver_controller.sv
hw/pov_display_top.sv
+incdir+tests
tests/tb_pov_display.sv

//--- hw/driver_controller.sv
/*
 * LED driver controller
 * On each accepted hall pulse, shifts every line of the column into the
 * drivers, latches it and selects it on the row multiplexer
 */
`timescale 1ns/1ps

module driver_controller (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 hall,
    input  logic                                                 display_enable,
    input  logic [pov_pkg::num_drivers-1:0][pov_pkg::pixel_w-1:0] rd_data,
    output logic [pov_pkg::line_w-1:0]                           rd_line,
    output logic                                                 drv_sclk,
    output logic                                                 drv_lat,
    output logic                                                 drv_gclk,
    output logic [pov_pkg::num_drivers-1:0]                      drv_sin,
    output logic [pov_pkg::num_lines-1:0]                        mux_out,
    output logic [15:0]                                          col_count
);

    typedef enum logic [1:0] {st_idle, st_read, st_shift, st_latch} state_t;

    state_t                      state;
    logic [2:0]                  hall_sync;
    logic                        hall_rise;
    logic [pov_pkg::line_w-1:0]  line_cnt;
    logic [4:0]                  bit_cnt;
    // Low half then high half of each serial bit
    logic                        phase;

    assign hall_rise = hall_sync[1] & ~hall_sync[2];
    assign rd_line = line_cnt;
    assign drv_sclk = (state == st_shift) && phase;
    assign drv_lat = (state == st_latch);

    // Pixel data is valid from the first shift cycle on
    always_comb begin
        for (int d = 0; d < pov_pkg::num_drivers; d++) begin
            drv_sin[d] = (state == st_shift) ? rd_data[d][bit_cnt] : 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            hall_sync <= '0;
            line_cnt <= '0;
            bit_cnt <= '0;
            phase <= 1'b0;
            mux_out <= '0;
            col_count <= '0;
            drv_gclk <= 1'b0;
        end else begin
            hall_sync <= {hall_sync[1:0], hall};
            drv_gclk <= display_enable & ~drv_gclk;
            case (state)
                st_idle: begin
                    if (!display_enable) begin
                        mux_out <= '0;
                    end
                    if (hall_rise && display_enable) begin
                        line_cnt <= '0;
                        col_count <= col_count + 1'b1;
                        state <= st_read;
                    end
                end
                st_read: begin
                    bit_cnt <= 5'(pov_pkg::pixel_w - 1);
                    phase <= 1'b0;
                    state <= st_shift;
                end
                st_shift: begin
                    phase <= ~phase;
                    if (phase) begin
                        if (bit_cnt == 5'd0) begin
                            state <= st_latch;
                        end else begin
                            bit_cnt <= bit_cnt - 1'b1;
                        end
                    end
                end
                st_latch: begin
                    mux_out <= '0;
                    mux_out[line_cnt] <= 1'b1;
                    if (int'(line_cnt) == pov_pkg::num_lines - 1) begin
                        state <= st_idle;
                    end else begin
                        line_cnt <= line_cnt + 1'b1;
                        state <= st_read;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // At most one row selected, and latch never overlaps a shift clock
    assert property (@(posedge clk) disable iff (reset) $onehot0(mux_out));
    assert property (@(posedge clk) disable iff (reset) !(drv_lat && drv_sclk));

endmodule

//--- hw/framebuffer.sv
/*
 * Pixel framebuffer
 * One pixel per driver and line, single write port and a registered
 * read port returning every driver's pixel of one line
 */
`timescale 1ns/1ps

module framebuffer (
    input  logic                                                 clk,
    input  logic                                                 wr_en,
    input  logic [pov_pkg::driver_w-1:0]                         wr_driver,
    input  logic [pov_pkg::line_w-1:0]                           wr_line,
    input  logic [pov_pkg::pixel_w-1:0]                          wr_data,
    input  logic [pov_pkg::line_w-1:0]                           rd_line,
    output logic [pov_pkg::num_drivers-1:0][pov_pkg::pixel_w-1:0] rd_data
);

    logic [pov_pkg::pixel_w-1:0] mem [pov_pkg::num_drivers][pov_pkg::num_lines];

    // Host side write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_driver][wr_line] <= wr_data;
        end
    end

    // Wide read, all lanes of one line at once
    always_ff @(posedge clk) begin
        for (int d = 0; d < pov_pkg::num_drivers; d++) begin
            rd_data[d] <= mem[d][rd_line];
        end
    end

    // Writes must target an existing driver with known indices
    assert property (@(posedge clk)
        wr_en |-> !$isunknown({wr_driver, wr_line}) &&
                  (int'(wr_driver) < pov_pkg::num_drivers));

endmodule

//--- hw/pov_display_top.sv
/*
 * POV display controller top level
 * Host SPI link, command decoder, framebuffer and LED driver sequencer
 */
`timescale 1ns/1ps

module pov_display_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           spi_sclk,
    input  logic                           spi_cs_n,
    input  logic                           spi_mosi,
    output logic                           spi_miso,
    input  logic                           hall,
    output logic                           drv_sclk,
    output logic                           drv_lat,
    output logic                           drv_gclk,
    output logic [pov_pkg::num_drivers-1:0] drv_sin,
    output logic [pov_pkg::num_lines-1:0]   mux_out
);

    // SPI byte link
    logic       rx_valid;
    logic [7:0] rx_byte;
    logic       frame_start;
    logic       frame_end;
    logic       tx_load;
    logic [7:0] tx_byte;

    // Framebuffer write side
    logic                         wr_en;
    logic [pov_pkg::driver_w-1:0] wr_driver;
    logic [pov_pkg::line_w-1:0]   wr_line;
    logic [pov_pkg::pixel_w-1:0]  wr_data;

    // Display side
    logic                                                 display_enable;
    logic [15:0]                                          col_count;
    logic [pov_pkg::line_w-1:0]                           rd_line;
    logic [pov_pkg::num_drivers-1:0][pov_pkg::pixel_w-1:0] rd_data;

    spi_slave spi_slave_i (
        .clk(clk), .reset(reset),
        .spi_sclk(spi_sclk), .spi_cs_n(spi_cs_n), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
        .tx_load(tx_load), .tx_byte(tx_byte),
        .rx_valid(rx_valid), .rx_byte(rx_byte),
        .frame_start(frame_start), .frame_end(frame_end)
    );

    spi_decoder spi_decoder_i (
        .clk(clk), .reset(reset),
        .rx_valid(rx_valid), .rx_byte(rx_byte),
        .frame_start(frame_start), .frame_end(frame_end),
        .col_count(col_count),
        .tx_load(tx_load), .tx_byte(tx_byte),
        .wr_en(wr_en), .wr_driver(wr_driver), .wr_line(wr_line), .wr_data(wr_data),
        .display_enable(display_enable)
    );

    framebuffer framebuffer_i (
        .clk(clk),
        .wr_en(wr_en), .wr_driver(wr_driver), .wr_line(wr_line), .wr_data(wr_data),
        .rd_line(rd_line), .rd_data(rd_data)
    );

    driver_controller driver_controller_i (
        .clk(clk), .reset(reset),
        .hall(hall), .display_enable(display_enable),
        .rd_data(rd_data), .rd_line(rd_line),
        .drv_sclk(drv_sclk), .drv_lat(drv_lat), .drv_gclk(drv_gclk), .drv_sin(drv_sin),
        .mux_out(mux_out), .col_count(col_count)
    );

endmodule

//--- hw/pov_pkg.sv
/*
 * POV display shared definitions
 * Display geometry, pixel format and the opcodes of the host SPI link
 */
package pov_pkg;

    // Display geometry
    // One serial lane per LED driver
    localparam int num_drivers = 4;
    // Pixel lines per column, one row multiplexer output each
    localparam int num_lines = 8;

    // Pixel format, R, G and B with 8 bits each
    localparam int pixel_w = 24;

    // Index widths
    localparam int line_w = $clog2(num_lines);
    localparam int driver_w = $clog2(num_drivers);

    // SPI command opcodes, always the first byte of a frame

    // Frame is driver, line, R, G, B
    localparam logic [7:0] op_write_pixel = 8'h01;

    // One data byte, bit 0 is display_enable
    localparam logic [7:0] op_control = 8'h02;

    // Reply is the 16-bit column counter, MSB first
    localparam logic [7:0] op_read_status = 8'h03;

endpackage

//--- hw/spi_decoder.sv
/*
 * SPI command decoder
 * Turns received frames into pixel writes, display control updates
 * and column counter replies
 */
`timescale 1ns/1ps

module spi_decoder (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          rx_valid,
    input  logic [7:0]                    rx_byte,
    input  logic                          frame_start,
    input  logic                          frame_end,
    input  logic [15:0]                   col_count,
    output logic                          tx_load,
    output logic [7:0]                    tx_byte,
    output logic                          wr_en,
    output logic [pov_pkg::driver_w-1:0]  wr_driver,
    output logic [pov_pkg::line_w-1:0]    wr_line,
    output logic [pov_pkg::pixel_w-1:0]   wr_data,
    output logic                          display_enable
);

    logic [2:0]  byte_idx;
    logic [7:0]  opcode;
    logic [7:0]  cur_op;
    logic [7:0]  pix_r;
    logic [7:0]  pix_g;
    logic [15:0] status_cap;

    // The opcode byte itself is decoded before it is latched
    assign cur_op = (byte_idx == 3'd0) ? rx_byte : opcode;

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_idx <= '0;
            opcode <= '0;
            tx_load <= 1'b0;
            wr_en <= 1'b0;
            display_enable <= 1'b0;
        end else begin
            tx_load <= 1'b0;
            wr_en <= 1'b0;
            if (frame_start) begin
                byte_idx <= '0;
            end else if (frame_end) begin
                // Drop whatever part of the frame was collected
                byte_idx <= '0;
                opcode <= '0;
            end else if (rx_valid) begin
                if (byte_idx != 3'd7) begin
                    byte_idx <= byte_idx + 1'b1;
                end
                if (byte_idx == 3'd0) begin
                    opcode <= rx_byte;
                end
                case (cur_op)
                    pov_pkg::op_write_pixel: begin
                        case (byte_idx)
                            3'd1: wr_driver <= rx_byte[pov_pkg::driver_w-1:0];
                            3'd2: wr_line <= rx_byte[pov_pkg::line_w-1:0];
                            3'd3: pix_r <= rx_byte;
                            3'd4: pix_g <= rx_byte;
                            3'd5: begin
                                wr_data <= {pix_r, pix_g, rx_byte};
                                wr_en <= 1'b1;
                            end
                            default: ;
                        endcase
                    end
                    pov_pkg::op_control: begin
                        if (byte_idx == 3'd1) begin
                            display_enable <= rx_byte[0];
                        end
                    end
                    pov_pkg::op_read_status: begin
                        // Snapshot the counter so both reply bytes match
                        if (byte_idx == 3'd0) begin
                            status_cap <= col_count;
                            tx_byte <= col_count[15:8];
                            tx_load <= 1'b1;
                        end else if (byte_idx == 3'd1) begin
                            tx_byte <= status_cap[7:0];
                            tx_load <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- hw/spi_slave.sv
/*
 * SPI slave, mode 0, MSB first
 * Brings sclk, cs_n and mosi into the clk domain, assembles received
 * bytes and shifts reply bytes out on miso
 */
`timescale 1ns/1ps

module spi_slave (
    input  logic       clk,
    input  logic       reset,
    input  logic       spi_sclk,
    input  logic       spi_cs_n,
    input  logic       spi_mosi,
    input  logic       tx_load,
    input  logic [7:0] tx_byte,
    output logic       spi_miso,
    output logic       rx_valid,
    output logic [7:0] rx_byte,
    output logic       frame_start,
    output logic       frame_end
);

    // Bits 0 and 1 synchronise, bit 2 holds the previous value
    logic [2:0] sclk_sync;
    logic [2:0] cs_sync;
    logic [1:0] mosi_sync;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       cs_active;
    logic [2:0] bit_cnt;
    logic [6:0] rx_shift;
    logic [7:0] tx_shift;
    logic [7:0] tx_next;

    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
    assign cs_active = ~cs_sync[1];
    assign spi_miso = tx_shift[7];

    always_ff @(posedge clk) begin
        if (reset) begin
            sclk_sync <= '0;
            cs_sync <= '1;
            mosi_sync <= '0;
            bit_cnt <= '0;
            rx_valid <= 1'b0;
            frame_start <= 1'b0;
            frame_end <= 1'b0;
            tx_shift <= '0;
            tx_next <= '0;
        end else begin
            sclk_sync <= {sclk_sync[1:0], spi_sclk};
            cs_sync <= {cs_sync[1:0], spi_cs_n};
            mosi_sync <= {mosi_sync[0], spi_mosi};
            rx_valid <= 1'b0;
            frame_start <= cs_sync[2] & ~cs_sync[1];
            frame_end <= ~cs_sync[2] & cs_sync[1];
            if (!cs_active) begin
                bit_cnt <= '0;
                tx_shift <= '0;
                tx_next <= '0;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 1'b1;
                rx_shift <= {rx_shift[5:0], mosi_sync[1]};
                if (bit_cnt == 3'd7) begin
                    rx_byte <= {rx_shift, mosi_sync[1]};
                    rx_valid <= 1'b1;
                end
            end else if (sclk_fall) begin
                // At a byte boundary the pending reply goes out next
                if (bit_cnt == 3'd0) begin
                    tx_shift <= tx_next;
                    tx_next <= '0;
                end else begin
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end
            if (tx_load) begin
                tx_next <= tx_byte;
            end
        end
    end

    // Received bytes only come from inside a frame
    assert property (@(posedge clk) disable iff (reset) rx_valid |-> cs_active);

endmodule

//--- tests/spi_host_tasks.svh
/*
 * SPI host tasks, mode 0, MSB first
 * Byte exchange and the command frames of the display controller
 */
`ifndef SPI_HOST_TASKS_SVH
`define SPI_HOST_TASKS_SVH

task automatic half_period_wait();
    repeat (spi_half) @(posedge clk);
endtask

task automatic select_slave();
    @(posedge clk);
    spi_cs_n <= 1'b0;
    half_period_wait();
endtask

task automatic release_slave();
    int waited;
    half_period_wait();
    spi_cs_n <= 1'b1;
    waited = 0;
    // Miso drops back low once the slave sees the frame end
    do begin
        @(posedge clk);
        waited++;
        if (waited > miso_timeout) abort_on_timeout("spi_miso to return low after a frame");
    end while (spi_miso !== 1'b0);
    half_period_wait();
endtask

// Mosi changes with sclk low, miso is taken just before the rising edge
task automatic transfer_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int b = 7; b >= 0; b--) begin
        spi_mosi <= tx[b];
        half_period_wait();
        rx[b] = spi_miso;
        spi_sclk <= 1'b1;
        half_period_wait();
        spi_sclk <= 1'b0;
    end
endtask

task automatic write_pixel_frame(input int drv, input int line, input logic [23:0] pix);
    logic [7:0] rx;
    select_slave();
    transfer_byte(pov_pkg::op_write_pixel, rx);
    transfer_byte(8'(drv), rx);
    transfer_byte(8'(line), rx);
    transfer_byte(pix[23:16], rx);
    transfer_byte(pix[15:8], rx);
    transfer_byte(pix[7:0], rx);
    release_slave();
endtask

task automatic write_control_frame(input logic enable);
    logic [7:0] rx;
    select_slave();
    transfer_byte(pov_pkg::op_control, rx);
    transfer_byte({7'd0, enable}, rx);
    release_slave();
endtask

// Reply bytes arrive during the two bytes after the opcode
task automatic read_status_frame(output logic [15:0] value);
    logic [7:0] rx;
    select_slave();
    transfer_byte(pov_pkg::op_read_status, rx);
    transfer_byte(8'h00, rx);
    value[15:8] = rx;
    transfer_byte(8'h00, rx);
    value[7:0] = rx;
    release_slave();
endtask

`endif

//--- tests/tb_pov_display.sv
/*
 * POV display controller testbench
 * Loads pixels over SPI, fires hall pulses and rebuilds the serial
 * driver words to compare them with a pixel model
 */
`timescale 1ns/1ps

module tb_pov_display;

    localparam int spi_half = 6;
    localparam int miso_timeout = 20;
    localparam int latch_timeout = 3000;
    localparam int settle_cycles = 450;
    localparam int seed = 42;

    logic                            clk;
    logic                            reset;
    logic                            spi_sclk;
    logic                            spi_cs_n;
    logic                            spi_mosi;
    logic                            spi_miso;
    logic                            hall;
    logic                            drv_sclk;
    logic                            drv_lat;
    logic                            drv_gclk;
    logic [pov_pkg::num_drivers-1:0] drv_sin;
    logic [pov_pkg::num_lines-1:0]   mux_out;

    // Pixel model and monitor state
    logic [pov_pkg::pixel_w-1:0] pixel_model [pov_pkg::num_drivers][pov_pkg::num_lines];
    logic [pov_pkg::pixel_w-1:0] shift_word [pov_pkg::num_drivers];
    int          error_count = 0;
    int          check_count = 0;
    int          latch_count = 0;
    int          bit_count = 0;
    int          accepted = 0;
    int          mux_line = 0;
    logic        mux_pending = 1'b0;
    logic        prev_sclk = 1'b0;
    logic        prev_lat = 1'b0;
    logic        gclk_on = 1'b0;
    logic        gclk_off = 1'b0;
    string       test_name = "reset";
    logic [15:0] status;

    pov_display_top pov_display_top_i (
        .clk(clk), .reset(reset),
        .spi_sclk(spi_sclk), .spi_cs_n(spi_cs_n), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
        .hall(hall),
        .drv_sclk(drv_sclk), .drv_lat(drv_lat), .drv_gclk(drv_gclk), .drv_sin(drv_sin),
        .mux_out(mux_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("ERR %s expected %0h actual %0h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        error_count++;
        finish_run();
    endtask

    `include "spi_host_tasks.svh"

    task automatic send_hall_pulse();
        @(posedge clk);
        hall <= 1'b1;
        repeat (4) @(posedge clk);
        hall <= 1'b0;
    endtask

    task automatic wait_for_latches(input int target);
        int waited;
        waited = 0;
        while (latch_count < target) begin
            @(posedge clk);
            waited++;
            if (waited > latch_timeout) abort_on_timeout("the column latches");
        end
    endtask

    // Waits out a full column more so that a restarted column would show
    task automatic check_column_count(input int target);
        wait_for_latches(target);
        repeat (settle_cycles) @(posedge clk);
        check_value({test_name, " latch count"}, target, latch_count);
    endtask

    // Rebuild driver words on sclk rises, compare them on each latch
    always @(negedge clk) begin : driver_monitor
        int line_idx;
        if (mux_pending) begin
            check_value($sformatf("%s mux line %0d", test_name, mux_line),
                        32'(1 << mux_line), 32'(mux_out));
            mux_pending = 1'b0;
        end
        if (drv_sclk && !prev_sclk) begin
            for (int d = 0; d < pov_pkg::num_drivers; d++) begin
                shift_word[d] = {shift_word[d][pov_pkg::pixel_w-2:0], drv_sin[d]};
            end
            bit_count++;
        end
        if (drv_lat && !prev_lat) begin
            line_idx = latch_count % pov_pkg::num_lines;
            check_value({test_name, " bits per line"}, pov_pkg::pixel_w, bit_count);
            for (int d = 0; d < pov_pkg::num_drivers; d++) begin
                check_value($sformatf("%s line %0d driver %0d", test_name, line_idx, d),
                            pixel_model[d][line_idx], shift_word[d]);
            end
            bit_count = 0;
            mux_line = line_idx;
            mux_pending = 1'b1;
            latch_count++;
        end
        prev_sclk = drv_sclk;
        prev_lat = drv_lat;
    end

    // Grey-scale clock while the display is on, and after it is switched off
    assert property (@(posedge clk) disable iff (reset)
        (gclk_on && $past(gclk_on)) |-> (drv_gclk != $past(drv_gclk)))
        else begin
            $display("drv_gclk did not toggle while the display was enabled");
            error_count++;
        end
    assert property (@(posedge clk) disable iff (reset) gclk_off |-> !drv_gclk)
        else begin
            $display("drv_gclk was high after the display was disabled");
            error_count++;
        end

    initial begin
        logic [pov_pkg::pixel_w-1:0] pix;
        logic [7:0]                  rx;
        hall = 1'b0;
        spi_sclk = 1'b0;
        spi_cs_n = 1'b1;
        spi_mosi = 1'b0;
        reset = 1'b1;
        void'($urandom(seed));
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("reset outputs", 0,
                    {drv_sclk, drv_lat, drv_gclk, drv_sin, mux_out, spi_miso});

        // Display still disabled, so the pulse is ignored
        test_name = "hall while disabled";
        send_hall_pulse();
        repeat (100) @(posedge clk);
        check_value({test_name, " latches"}, 0, latch_count);
        check_value({test_name, " sclk pulses"}, 0, bit_count);

        test_name = "column readout";
        for (int d = 0; d < pov_pkg::num_drivers; d++) begin
            for (int l = 0; l < pov_pkg::num_lines; l++) begin
                pix = pov_pkg::pixel_w'($urandom);
                pixel_model[d][l] = pix;
                write_pixel_frame(d, l, pix);
            end
        end
        write_control_frame(1'b1);
        gclk_on <= 1'b1;
        send_hall_pulse();
        accepted++;
        check_column_count(8);

        test_name = "hall during column";
        send_hall_pulse();
        accepted++;
        wait_for_latches(10);
        send_hall_pulse();
        check_column_count(16);

        read_status_frame(status);
        check_value("status read", accepted, status);

        // Frame ends after the line byte and must leave every pixel as it was
        test_name = "cut write frame";
        select_slave();
        transfer_byte(pov_pkg::op_write_pixel, rx);
        transfer_byte(8'd2, rx);
        transfer_byte(8'd5, rx);
        release_slave();
        // A full frame after it must not complete the cut one
        pix = pov_pkg::pixel_w'($urandom);
        pixel_model[1][3] = pix;
        write_pixel_frame(1, 3, pix);
        send_hall_pulse();
        accepted++;
        check_column_count(24);

        test_name = "display off";
        gclk_on <= 1'b0;
        write_control_frame(1'b0);
        repeat (4) @(posedge clk);
        gclk_off <= 1'b1;
        repeat (100) @(posedge clk);
        finish_run();
    end

endmodule
